// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
TOP       ?= lsu_subsys_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf $(OBJ_DIR)

// File: dv/lsu_subsys_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_subsys_tb;

	localparam logic [2:0] f_b  = 3'b000;
	localparam logic [2:0] f_h  = 3'b001;
	localparam logic [2:0] f_w  = 3'b010;
	localparam logic [2:0] f_bu = 3'b100;
	localparam logic [2:0] f_hu = 3'b101;

	localparam logic [1:0] okay   = lsu_pkg::resp_okay;
	localparam logic [1:0] slverr = lsu_pkg::resp_slverr;

	localparam int rnd_ops   = 64;
	localparam int op_cycles = lsu_pkg::ram_wait + 10;

	logic        clock;
	logic        arst_n;
	logic [2:0]  funct3;
	logic [31:0] src1;
	logic [31:0] src2;
	logic [31:0] imm;
	logic [7:0]  wmask;
	logic        lsu_ren;
	logic        lsu_wen;
	logic [31:0] lsu_val;
	logic        load_done;
	logic        store_done;
	logic [1:0]  resp;

	string       t_name [$];
	bit          t_store [$];
	logic [2:0]  t_funct3 [$];
	logic [31:0] t_src1 [$];
	logic [31:0] t_imm [$];
	logic [31:0] t_src2 [$];
	logic [7:0]  t_wmask [$];
	logic [31:0] t_val [$];
	logic [1:0]  t_resp [$];

	// Word images of the scratchpad and the RAM for the random phase.
	logic [31:0] scr_model [2048];
	logic [31:0] ram_model [1024];
	logic [31:0] rnd_addr [$];

	bit          table_ready;
	int          checks;
	int          val_errors;
	int          resp_errors;
	int          done_errors;

	lsu_subsys lsu_subsys_inst (.*);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	function automatic logic [7:0] store_mask(input logic [2:0] f3);
		case (f3[1:0])
			2'b00:   return 8'h01;
			2'b01:   return 8'h03;
			default: return 8'h0f;
		endcase
	endfunction

	task automatic add_store(input string name, input logic [2:0] f3, input logic [31:0] base,
			input logic [31:0] off, input logic [31:0] data, input logic [1:0] exp_resp);
		t_name.push_back(name);
		t_store.push_back(1'b1);
		t_funct3.push_back(f3);
		t_src1.push_back(base);
		t_imm.push_back(off);
		t_src2.push_back(data);
		t_wmask.push_back(store_mask(f3));
		t_val.push_back(32'h0);
		t_resp.push_back(exp_resp);
	endtask

	task automatic add_load(input string name, input logic [2:0] f3, input logic [31:0] base,
			input logic [31:0] off, input logic [31:0] exp_val, input logic [1:0] exp_resp);
		t_name.push_back(name);
		t_store.push_back(1'b0);
		t_funct3.push_back(f3);
		t_src1.push_back(base);
		t_imm.push_back(off);
		t_src2.push_back(32'h0);
		t_wmask.push_back(8'h00);
		t_val.push_back(exp_val);
		t_resp.push_back(exp_resp);
	endtask

	task automatic build_table();
		// Scratchpad, both halves of one doubleword.
		add_store("scr_sw_lo", f_w, 32'h0f00_0100, 32'h0, 32'h1122_3344, okay);
		add_store("scr_sw_hi", f_w, 32'h0f00_0100, 32'h4, 32'ha5a5_5a5a, okay);
		add_load("scr_lw_lo", f_w, 32'h0f00_0100, 32'h0, 32'h1122_3344, okay);
		add_load("scr_lw_hi", f_w, 32'h0f00_0100, 32'h4, 32'ha5a5_5a5a, okay);
		add_load("scr_lb_5", f_b, 32'h0f00_0100, 32'h5, 32'h0000_005a, okay);
		add_load("scr_lbu_7", f_bu, 32'h0f00_0100, 32'h7, 32'h0000_00a5, okay);
		add_load("scr_lh_6", f_h, 32'h0f00_0100, 32'h6, 32'hffff_a5a5, okay);

		// RAM byte lanes.
		add_store("ram_sw_init", f_w, 32'h8000_0200, 32'h0, 32'hffff_ffff, okay);
		add_store("ram_sb_0", f_b, 32'h8000_0200, 32'h0, 32'h0000_0081, okay);
		add_load("ram_lw_sb0", f_w, 32'h8000_0200, 32'h0, 32'hffff_ff81, okay);
		add_store("ram_sb_1", f_b, 32'h8000_0200, 32'h1, 32'h0000_007f, okay);
		add_store("ram_sb_2", f_b, 32'h8000_0200, 32'h2, 32'h0000_00c3, okay);
		add_store("ram_sb_3", f_b, 32'h8000_0200, 32'h3, 32'h1234_5654, okay);
		add_load("ram_lw_bytes", f_w, 32'h8000_0200, 32'h0, 32'h54c3_7f81, okay);
		add_load("ram_lb_0", f_b, 32'h8000_0200, 32'h0, 32'hffff_ff81, okay);
		add_load("ram_lbu_0", f_bu, 32'h8000_0200, 32'h0, 32'h0000_0081, okay);
		add_load("ram_lb_1", f_b, 32'h8000_0200, 32'h1, 32'h0000_007f, okay);
		add_load("ram_lb_2", f_b, 32'h8000_0200, 32'h2, 32'hffff_ffc3, okay);
		add_load("ram_lbu_2", f_bu, 32'h8000_0200, 32'h2, 32'h0000_00c3, okay);
		add_load("ram_lb_3", f_b, 32'h8000_0200, 32'h3, 32'h0000_0054, okay);

		// RAM halfwords.
		add_store("ram_sh_2", f_h, 32'h8000_0200, 32'h2, 32'h0000_beef, okay);
		add_load("ram_lh_2", f_h, 32'h8000_0200, 32'h2, 32'hffff_beef, okay);
		add_load("ram_lhu_2", f_hu, 32'h8000_0200, 32'h2, 32'h0000_beef, okay);
		add_load("ram_lh_0", f_h, 32'h8000_0200, 32'h0, 32'h0000_7f81, okay);
		add_store("ram_sh_0", f_h, 32'h8000_0200, 32'h0, 32'h0000_8001, okay);
		add_load("ram_lh_0_neg", f_h, 32'h8000_0200, 32'h0, 32'hffff_8001, okay);
		add_load("ram_lhu_0", f_hu, 32'h8000_0200, 32'h0, 32'h0000_8001, okay);

		// RAM word in the upper lane half.
		add_store("ram_sw_hi", f_w, 32'h8000_0204, 32'h0, 32'hcafe_f00d, okay);
		add_load("ram_lw_hi", f_w, 32'h8000_0204, 32'h0, 32'hcafe_f00d, okay);
		add_load("ram_lbu_7", f_bu, 32'h8000_0204, 32'h3, 32'h0000_00ca, okay);
		add_load("ram_lb_6", f_b, 32'h8000_0204, 32'h2, 32'hffff_fffe, okay);

		// Negative offsets.
		add_load("neg_lw_ram", f_w, 32'h8000_0210, 32'hffff_fff0, 32'hbeef_8001, okay);
		add_store("neg_sw_scr", f_w, 32'h0f00_0120, 32'hffff_ffe8, 32'h1357_9bdf, okay);
		add_load("pos_lw_scr", f_w, 32'h0f00_0100, 32'h8, 32'h1357_9bdf, okay);
		add_store("neg_sb_ram", f_b, 32'h8000_0208, 32'hffff_fffd, 32'h0000_0099, okay);
		add_load("pos_lw_ram", f_w, 32'h8000_0200, 32'h4, 32'hcafe_990d, okay);

		// Upper RAM address bits are aliases.
		add_store("wrap_sw", f_w, 32'h8000_1200, 32'h0, 32'h0bad_f00d, okay);
		add_load("wrap_lw_base", f_w, 32'h8000_0200, 32'h0, 32'h0bad_f00d, okay);
		add_load("wrap_lw_top", f_w, 32'hbfff_f200, 32'h0, 32'h0bad_f00d, okay);

		// Device registers.
		add_store("dev_sw_0", f_w, 32'h1000_0000, 32'h0, 32'hdead_beef, okay);
		add_store("dev_sw_1", f_w, 32'h1000_0004, 32'h0, 32'h0123_4567, okay);
		add_store("dev_sw_3", f_w, 32'h1000_000c, 32'h0, 32'h89ab_cdef, okay);
		add_load("dev_lw_0", f_w, 32'h1000_0000, 32'h0, 32'hdead_beef, okay);
		add_load("dev_lb_1", f_b, 32'h1000_0000, 32'h1, 32'hffff_ffbe, okay);
		add_load("dev_lbu_3", f_bu, 32'h1000_0000, 32'h3, 32'h0000_00de, okay);
		add_load("dev_lhu_2", f_hu, 32'h1000_0000, 32'h2, 32'h0000_dead, okay);
		add_load("dev_lh_0", f_h, 32'h1000_0000, 32'h0, 32'hffff_beef, okay);
		add_store("dev_sb_d", f_b, 32'h1000_000c, 32'h1, 32'h0000_0055, okay);
		add_load("dev_lw_3", f_w, 32'h1000_000c, 32'h0, 32'h89ab_55ef, okay);
		add_store("dev_sh_6", f_h, 32'h1000_0004, 32'h2, 32'h0000_aaaa, okay);
		add_load("dev_lw_1", f_w, 32'h1000_0004, 32'h0, 32'haaaa_4567, okay);

		// Outside the four-register window.
		add_load("dev_lw_miss", f_w, 32'h1000_0010, 32'h0, 32'h0, slverr);
		add_store("dev_sw_miss", f_w, 32'h1000_0020, 32'h0, 32'h0000_0001, slverr);
		add_load("dev_lw_kept", f_w, 32'h1000_0000, 32'h0, 32'hdead_beef, okay);
	endtask

	// One access from strobe to completion.
	task automatic do_access(input bit store, input logic [2:0] f3, input logic [31:0] base,
			input logic [31:0] off, input logic [31:0] data, input logic [7:0] mask,
			output logic [31:0] val, output logic [1:0] rsp);
		@(negedge clock);
		funct3  = f3;
		src1    = base;
		imm     = off;
		src2    = data;
		wmask   = mask;
		lsu_ren = !store;
		lsu_wen = store;
		@(negedge clock);
		lsu_ren = 1'b0;
		lsu_wen = 1'b0;
		while (!(load_done || store_done)) begin
			@(negedge clock);
		end
		assert (store ? (store_done && !load_done) : (load_done && !store_done)) else begin
			done_errors++;
			$display("Wrong completion signal raised for a %s", store ? "store" : "load");
		end
		val = lsu_val;
		rsp = resp;
	endtask

	task automatic check_result(input string name, input logic [31:0] exp_val,
			input logic [31:0] got_val, input logic [1:0] exp_resp, input logic [1:0] got_resp);
		checks++;
		assert (got_val === exp_val) else begin
			val_errors++;
			$display("CHECK FAILED %s value expected %h actual %h", name, exp_val, got_val);
		end
		assert (got_resp === exp_resp) else begin
			resp_errors++;
			$display("CHECK FAILED %s resp expected %b actual %b", name, exp_resp, got_resp);
		end
	endtask

	task automatic run_random();
		logic [31:0] addr;
		logic [31:0] off;
		logic [31:0] data;
		logic [31:0] r;
		logic [31:0] exp_val;
		logic [31:0] got_val;
		logic [1:0]  got_resp;
		int          idx;
		for (int i = 0; i < rnd_ops; i++) begin
			r = $urandom;
			if (r[0]) begin
				addr = lsu_pkg::ram_base | ($urandom & 32'h3fff_fffc);
			end else begin
				addr = lsu_pkg::scratch_base | ($urandom & 32'h0000_1ffc);
			end
			r    = $urandom;
			off  = {{20{r[11]}}, r[11:0]};
			data = $urandom;
			do_access(1'b1, f_w, addr - off, off, data, 8'h0f, got_val, got_resp);
			check_result($sformatf("rnd_sw_%0d", i), 32'h0, got_val, okay, got_resp);
			if (addr[31]) begin
				ram_model[addr[11:2]] = data;
			end else begin
				scr_model[addr[12:2]] = data;
			end
			rnd_addr.push_back(addr);
		end
		for (int i = 0; i < rnd_ops; i++) begin
			idx  = int'($urandom % rnd_ops);
			addr = rnd_addr[idx];
			r    = $urandom;
			// Same RAM word through other upper bits.
			if (addr[31] && r[0]) begin
				addr = {addr[31:30], r[29:12], addr[11:0]};
			end
			exp_val = addr[31] ? ram_model[addr[11:2]] : scr_model[addr[12:2]];
			r       = $urandom;
			off     = {{20{r[11]}}, r[11:0]};
			do_access(1'b0, f_w, addr - off, off, 32'h0, 8'h00, got_val, got_resp);
			check_result($sformatf("rnd_lw_%0d", i), exp_val, got_val, okay, got_resp);
		end
	endtask

	initial begin
		logic [31:0] got_val;
		logic [1:0]  got_resp;
		void'($urandom(32'he0d0_5478));
		arst_n  = 1'b0;
		funct3  = 3'b000;
		src1    = 32'h0;
		src2    = 32'h0;
		imm     = 32'h0;
		wmask   = 8'h00;
		lsu_ren = 1'b0;
		lsu_wen = 1'b0;
		build_table();
		table_ready = 1'b1;
		repeat (3) @(posedge clock);
		@(negedge clock);
		arst_n = 1'b1;

		for (int i = 0; i < t_name.size(); i++) begin
			do_access(t_store[i], t_funct3[i], t_src1[i], t_imm[i], t_src2[i], t_wmask[i],
				got_val, got_resp);
			check_result(t_name[i], t_val[i], got_val, t_resp[i], got_resp);
		end

		run_random();

		$display("Checks: %0d, value errors: %0d, resp errors: %0d, done errors: %0d",
			checks, val_errors, resp_errors, done_errors);
		if (val_errors == 0 && resp_errors == 0 && done_errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	// Bound covers reset plus every table and random access.
	initial begin
		int limit;
		wait (table_ready);
		limit = (t_name.size() + 2 * rnd_ops) * op_cycles + 10;
		repeat (limit) @(posedge clock);
		$display("Timeout: accesses still pending after %0d cycles", limit);
		$display("Checks: %0d, value errors: %0d, resp errors: %0d, done errors: %0d",
			checks, val_errors, resp_errors, done_errors);
		$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
verilog/lsu_pkg.sv
verilog/lsu.sv
verilog/lsu_xbar.sv
verilog/scratch_slave.sv
verilog/ram_slave.sv
verilog/dev_slave.sv
verilog/lsu_subsys.sv
dv/lsu_subsys_tb.sv

// File: verilog/dev_slave.sv
`timescale 1ns/1ps
`default_nettype none

module dev_slave (
	input  logic        clock,
	input  logic        arst_n,
	input  logic [31:0] araddr,
	input  logic        arvalid,
	input  logic [2:0]  arsize,
	output logic        arready,
	output logic [63:0] rdata,
	output logic [1:0]  rresp,
	output logic        rvalid,
	input  logic        rready,
	input  logic [31:0] awaddr,
	input  logic        awvalid,
	input  logic [2:0]  awsize,
	output logic        awready,
	input  logic [63:0] wdata,
	input  logic [7:0]  wstrb,
	input  logic        wvalid,
	output logic        wready,
	output logic [1:0]  bresp,
	output logic        bvalid,
	input  logic        bready
);

	logic [31:0] regs [4];
	logic        rd_fire;
	logic        wr_fire;
	logic        rd_hit;
	logic        wr_hit;
	logic [31:0] rword;
	logic [31:0] wword;
	logic [3:0]  wlane;

	assign arready = !rvalid;
	assign awready = !bvalid && wvalid;
	assign wready  = !bvalid && awvalid;
	assign rd_fire = arvalid && arready;
	assign wr_fire = awvalid && awready;

	// Inside the four-word window and no wider than a word.
	assign rd_hit = araddr[31:4] == lsu_pkg::dev_base[31:4] && arsize <= 3'd2;
	assign wr_hit = awaddr[31:4] == lsu_pkg::dev_base[31:4] && awsize <= 3'd2;

	assign wword = awaddr[2] ? wdata[63:32] : wdata[31:0];
	assign wlane = awaddr[2] ? wstrb[7:4] : wstrb[3:0];
	assign rdata = {32'h0, rword};

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			rvalid <= 1'b0;
			bvalid <= 1'b0;
		end else begin
			rvalid <= rd_fire || (rvalid && !rready);
			bvalid <= wr_fire || (bvalid && !bready);
		end
	end

	always_ff @(posedge clock) begin
		if (rd_fire) begin
			rword <= rd_hit ? regs[araddr[3:2]] >> {araddr[1:0], 3'b000} : 32'h0;
			rresp <= rd_hit ? lsu_pkg::resp_okay : lsu_pkg::resp_slverr;
		end
		if (wr_fire) begin
			bresp <= wr_hit ? lsu_pkg::resp_okay : lsu_pkg::resp_slverr;
			for (int i = 0; i < 4; i++) begin
				if (wlane[i] && wr_hit) begin
					regs[awaddr[3:2]][8*i +: 8] <= wword[8*i +: 8];
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/lsu.sv
`timescale 1ns/1ps
`default_nettype none

module lsu (
	input  logic             clock,
	input  logic             arst_n,
	input  logic [2:0]       funct3,
	input  logic [31:0]      src1,
	input  logic [31:0]      src2,
	input  logic [31:0]      imm,
	input  logic [7:0]       wmask,
	input  logic             lsu_ren,
	input  logic             lsu_wen,
	output logic [31:0]      araddr,
	output logic             arvalid,
	output logic [2:0]       arsize,
	input  logic             arready,
	input  logic [63:0]      rdata,
	input  logic [1:0]       rresp,
	input  logic             rvalid,
	output logic             rready,
	output logic [31:0]      awaddr,
	output logic             awvalid,
	output logic [2:0]       awsize,
	input  logic             awready,
	output logic [63:0]      wdata,
	output logic [7:0]       wstrb,
	output logic             wvalid,
	input  logic             wready,
	input  logic [1:0]       bresp,
	input  logic             bvalid,
	output logic             bready,
	output lsu_pkg::region_t ar_region,
	output lsu_pkg::region_t aw_region,
	output logic [31:0]      lsu_val,
	output logic             load_done
);

	logic [31:0]      addr;
	lsu_pkg::region_t region;
	logic [31:0]      rword;
	logic [31:0]      rshift;
	logic [31:0]      rext;

	assign addr = src1 + imm;

	always_comb begin
		if (addr >= lsu_pkg::scratch_base && addr <= lsu_pkg::scratch_limit) begin
			region = lsu_pkg::region_scratch;
		end else if (addr >= lsu_pkg::ram_base && addr <= lsu_pkg::ram_limit) begin
			region = lsu_pkg::region_ram;
		end else begin
			region = lsu_pkg::region_dev;
		end
	end

	assign araddr    = addr;
	assign awaddr    = addr;
	assign ar_region = region;
	assign aw_region = region;
	assign arsize    = {1'b0, funct3[1:0]};
	assign awsize    = {1'b0, funct3[1:0]};

	// Store data moves into the byte lanes of the addressed doubleword.
	assign wstrb = wmask << addr[2:0];
	assign wdata = {32'h0, src2} << {addr[2:0], 3'b000};

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			arvalid <= 1'b0;
			awvalid <= 1'b0;
			wvalid  <= 1'b0;
			rready  <= 1'b0;
		end else begin
			arvalid <= arvalid ? !arready : lsu_ren;
			awvalid <= awvalid ? !awready : lsu_wen;
			wvalid  <= wvalid ? !wready : lsu_wen;
			rready  <= !rready && rvalid;
		end
	end

	assign bready    = 1'b1;
	assign load_done = rvalid && rready;

	// Scratchpad returns a whole doubleword.
	assign rword  = (region == lsu_pkg::region_scratch && addr[2]) ? rdata[63:32] : rdata[31:0];
	// Device data is already right-aligned.
	assign rshift = (region == lsu_pkg::region_dev) ? rword : rword >> {addr[1:0], 3'b000};

	always_comb begin
		case (funct3)
			3'b000:  rext = {{24{rshift[7]}}, rshift[7:0]};
			3'b001:  rext = {{16{rshift[15]}}, rshift[15:0]};
			3'b010:  rext = rshift;
			3'b100:  rext = {24'h0, rshift[7:0]};
			3'b101:  rext = {16'h0, rshift[15:0]};
			default: rext = 32'h0;
		endcase
	end

	assign lsu_val = load_done ? rext : 32'h0;

	// A read request holds with a steady address until the slave takes it.
	assert property (@(posedge clock) disable iff (!arst_n)
		arvalid && !arready |=> arvalid && $stable(araddr));

	assert property (@(posedge clock) disable iff (!arst_n) !(lsu_ren && lsu_wen));

	// No slave answers with the reserved code.
	assert property (@(posedge clock) disable iff (!arst_n)
		!(rvalid && rresp == 2'b01) && !(bvalid && bresp == 2'b01));

endmodule

`default_nettype wire

// File: verilog/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

	typedef enum logic [1:0] {
		region_scratch = 2'd0,
		region_ram     = 2'd1,
		region_dev     = 2'd2
	} region_t;

	// Scratchpad window, 8 KiB.
	localparam logic [31:0] scratch_base  = 32'h0f00_0000;
	localparam logic [31:0] scratch_limit = 32'h0f00_1fff;

	// Main RAM window. Only 4 KiB is backed, so it wraps.
	localparam logic [31:0] ram_base  = 32'h8000_0000;
	localparam logic [31:0] ram_limit = 32'hbfff_ffff;

	// Device window of four words.
	localparam logic [31:0] dev_base = 32'h1000_0000;

	localparam logic [1:0] resp_okay   = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;
	localparam logic [1:0] resp_decerr = 2'b11;

	// Cycles from RAM request to response, two or more.
	localparam int ram_wait = 3;

	localparam int scratch_words = 1024;
	localparam int ram_words     = 1024;

endpackage

`default_nettype wire

// File: verilog/lsu_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_subsys (
	input  logic        clock,
	input  logic        arst_n,
	input  logic [2:0]  funct3,
	input  logic [31:0] src1,
	input  logic [31:0] src2,
	input  logic [31:0] imm,
	input  logic [7:0]  wmask,
	input  logic        lsu_ren,
	input  logic        lsu_wen,
	output logic [31:0] lsu_val,
	output logic        load_done,
	output logic        store_done,
	output logic [1:0]  resp
);

	logic [31:0]      araddr, scr_araddr, ram_araddr, dev_araddr;
	logic             arvalid, scr_arvalid, ram_arvalid, dev_arvalid;
	logic [2:0]       arsize, scr_arsize, ram_arsize, dev_arsize;
	logic             arready, scr_arready, ram_arready, dev_arready;
	logic [63:0]      rdata, scr_rdata, ram_rdata, dev_rdata;
	logic [1:0]       rresp, scr_rresp, ram_rresp, dev_rresp;
	logic             rvalid, scr_rvalid, ram_rvalid, dev_rvalid;
	logic             rready, scr_rready, ram_rready, dev_rready;
	logic [31:0]      awaddr, scr_awaddr, ram_awaddr, dev_awaddr;
	logic             awvalid, scr_awvalid, ram_awvalid, dev_awvalid;
	logic [2:0]       awsize, scr_awsize, ram_awsize, dev_awsize;
	logic             awready, scr_awready, ram_awready, dev_awready;
	logic [63:0]      wdata, scr_wdata, ram_wdata, dev_wdata;
	logic [7:0]       wstrb, scr_wstrb, ram_wstrb, dev_wstrb;
	logic             wvalid, scr_wvalid, ram_wvalid, dev_wvalid;
	logic             wready, scr_wready, ram_wready, dev_wready;
	logic [1:0]       bresp, scr_bresp, ram_bresp, dev_bresp;
	logic             bvalid, scr_bvalid, ram_bvalid, dev_bvalid;
	logic             bready, scr_bready, ram_bready, dev_bready;
	lsu_pkg::region_t ar_region;
	lsu_pkg::region_t aw_region;

	lsu lsu_inst (.*);

	lsu_xbar lsu_xbar_inst (.*);

	scratch_slave scratch_slave_inst (
		.clock   (clock),
		.arst_n  (arst_n),
		.araddr  (scr_araddr),
		.arvalid (scr_arvalid),
		.arsize  (scr_arsize),
		.arready (scr_arready),
		.rdata   (scr_rdata),
		.rresp   (scr_rresp),
		.rvalid  (scr_rvalid),
		.rready  (scr_rready),
		.awaddr  (scr_awaddr),
		.awvalid (scr_awvalid),
		.awsize  (scr_awsize),
		.awready (scr_awready),
		.wdata   (scr_wdata),
		.wstrb   (scr_wstrb),
		.wvalid  (scr_wvalid),
		.wready  (scr_wready),
		.bresp   (scr_bresp),
		.bvalid  (scr_bvalid),
		.bready  (scr_bready)
	);

	ram_slave ram_slave_inst (
		.clock   (clock),
		.arst_n  (arst_n),
		.araddr  (ram_araddr),
		.arvalid (ram_arvalid),
		.arsize  (ram_arsize),
		.arready (ram_arready),
		.rdata   (ram_rdata),
		.rresp   (ram_rresp),
		.rvalid  (ram_rvalid),
		.rready  (ram_rready),
		.awaddr  (ram_awaddr),
		.awvalid (ram_awvalid),
		.awsize  (ram_awsize),
		.awready (ram_awready),
		.wdata   (ram_wdata),
		.wstrb   (ram_wstrb),
		.wvalid  (ram_wvalid),
		.wready  (ram_wready),
		.bresp   (ram_bresp),
		.bvalid  (ram_bvalid),
		.bready  (ram_bready)
	);

	dev_slave dev_slave_inst (
		.clock   (clock),
		.arst_n  (arst_n),
		.araddr  (dev_araddr),
		.arvalid (dev_arvalid),
		.arsize  (dev_arsize),
		.arready (dev_arready),
		.rdata   (dev_rdata),
		.rresp   (dev_rresp),
		.rvalid  (dev_rvalid),
		.rready  (dev_rready),
		.awaddr  (dev_awaddr),
		.awvalid (dev_awvalid),
		.awsize  (dev_awsize),
		.awready (dev_awready),
		.wdata   (dev_wdata),
		.wstrb   (dev_wstrb),
		.wvalid  (dev_wvalid),
		.wready  (dev_wready),
		.bresp   (dev_bresp),
		.bvalid  (dev_bvalid),
		.bready  (dev_bready)
	);

	assign store_done = bvalid && bready;

	// Response of whichever access completes this cycle.
	assign resp = load_done ? rresp : (store_done ? bresp : lsu_pkg::resp_okay);

endmodule

`default_nettype wire

// File: verilog/lsu_xbar.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_xbar (
	input  logic             clock,
	input  logic             arst_n,
	input  logic [31:0]      araddr,
	input  logic             arvalid,
	input  logic [2:0]       arsize,
	output logic             arready,
	output logic [63:0]      rdata,
	output logic [1:0]       rresp,
	output logic             rvalid,
	input  logic             rready,
	input  logic [31:0]      awaddr,
	input  logic             awvalid,
	input  logic [2:0]       awsize,
	output logic             awready,
	input  logic [63:0]      wdata,
	input  logic [7:0]       wstrb,
	input  logic             wvalid,
	output logic             wready,
	output logic [1:0]       bresp,
	output logic             bvalid,
	input  logic             bready,
	input  lsu_pkg::region_t ar_region,
	input  lsu_pkg::region_t aw_region,
	output logic [31:0]      scr_araddr, ram_araddr, dev_araddr,
	output logic             scr_arvalid, ram_arvalid, dev_arvalid,
	output logic [2:0]       scr_arsize, ram_arsize, dev_arsize,
	input  logic             scr_arready, ram_arready, dev_arready,
	input  logic [63:0]      scr_rdata, ram_rdata, dev_rdata,
	input  logic [1:0]       scr_rresp, ram_rresp, dev_rresp,
	input  logic             scr_rvalid, ram_rvalid, dev_rvalid,
	output logic             scr_rready, ram_rready, dev_rready,
	output logic [31:0]      scr_awaddr, ram_awaddr, dev_awaddr,
	output logic             scr_awvalid, ram_awvalid, dev_awvalid,
	output logic [2:0]       scr_awsize, ram_awsize, dev_awsize,
	input  logic             scr_awready, ram_awready, dev_awready,
	output logic [63:0]      scr_wdata, ram_wdata, dev_wdata,
	output logic [7:0]       scr_wstrb, ram_wstrb, dev_wstrb,
	output logic             scr_wvalid, ram_wvalid, dev_wvalid,
	input  logic             scr_wready, ram_wready, dev_wready,
	input  logic [1:0]       scr_bresp, ram_bresp, dev_bresp,
	input  logic             scr_bvalid, ram_bvalid, dev_bvalid,
	output logic             scr_bready, ram_bready, dev_bready
);

	lsu_pkg::region_t rd_sel;
	lsu_pkg::region_t wr_sel;
	lsu_pkg::region_t rd_route;
	lsu_pkg::region_t wr_route;
	logic             rd_busy;
	logic             wr_busy;

	// Payload is broadcast. Only the valids are steered.
	assign {scr_araddr, ram_araddr, dev_araddr} = {3{araddr}};
	assign {scr_arsize, ram_arsize, dev_arsize} = {3{arsize}};
	assign {scr_awaddr, ram_awaddr, dev_awaddr} = {3{awaddr}};
	assign {scr_awsize, ram_awsize, dev_awsize} = {3{awsize}};
	assign {scr_wdata, ram_wdata, dev_wdata}    = {3{wdata}};
	assign {scr_wstrb, ram_wstrb, dev_wstrb}    = {3{wstrb}};

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			rd_busy <= 1'b0;
			wr_busy <= 1'b0;
			rd_sel  <= lsu_pkg::region_scratch;
			wr_sel  <= lsu_pkg::region_scratch;
		end else begin
			if (arvalid && arready) begin
				rd_busy <= 1'b1;
				rd_sel  <= ar_region;
			end else if (rvalid && rready) begin
				rd_busy <= 1'b0;
			end
			if (awvalid && awready) begin
				wr_busy <= 1'b1;
				wr_sel  <= aw_region;
			end else if (bvalid && bready) begin
				wr_busy <= 1'b0;
			end
		end
	end

	assign rd_route = rd_busy ? rd_sel : ar_region;
	assign wr_route = wr_busy ? wr_sel : aw_region;

	always_comb begin
		{scr_arvalid, ram_arvalid, dev_arvalid} = 3'b000;
		{scr_rready, ram_rready, dev_rready}    = 3'b000;
		// Unmapped region answers a decode error itself.
		arready = 1'b1;
		rvalid  = rd_busy;
		rdata   = 64'h0;
		rresp   = lsu_pkg::resp_decerr;
		case (rd_route)
			lsu_pkg::region_scratch: begin
				scr_arvalid = arvalid;
				scr_rready  = rready;
				arready     = scr_arready;
				rvalid      = scr_rvalid;
				rdata       = scr_rdata;
				rresp       = scr_rresp;
			end
			lsu_pkg::region_ram: begin
				ram_arvalid = arvalid;
				ram_rready  = rready;
				arready     = ram_arready;
				rvalid      = ram_rvalid;
				rdata       = ram_rdata;
				rresp       = ram_rresp;
			end
			lsu_pkg::region_dev: begin
				dev_arvalid = arvalid;
				dev_rready  = rready;
				arready     = dev_arready;
				rvalid      = dev_rvalid;
				rdata       = dev_rdata;
				rresp       = dev_rresp;
			end
			default: ;
		endcase
	end

	always_comb begin
		{scr_awvalid, ram_awvalid, dev_awvalid} = 3'b000;
		{scr_wvalid, ram_wvalid, dev_wvalid}    = 3'b000;
		{scr_bready, ram_bready, dev_bready}    = 3'b000;
		awready = 1'b1;
		wready  = 1'b1;
		bvalid  = wr_busy;
		bresp   = lsu_pkg::resp_decerr;
		case (wr_route)
			lsu_pkg::region_scratch: begin
				scr_awvalid = awvalid;
				scr_wvalid  = wvalid;
				scr_bready  = bready;
				awready     = scr_awready;
				wready      = scr_wready;
				bvalid      = scr_bvalid;
				bresp       = scr_bresp;
			end
			lsu_pkg::region_ram: begin
				ram_awvalid = awvalid;
				ram_wvalid  = wvalid;
				ram_bready  = bready;
				awready     = ram_awready;
				wready      = ram_wready;
				bvalid      = ram_bvalid;
				bresp       = ram_bresp;
			end
			lsu_pkg::region_dev: begin
				dev_awvalid = awvalid;
				dev_wvalid  = wvalid;
				dev_bready  = bready;
				awready     = dev_awready;
				wready      = dev_wready;
				bvalid      = dev_bvalid;
				bresp       = dev_bresp;
			end
			default: ;
		endcase
	end

	// The unit keeps a single read in flight.
	assert property (@(posedge clock) disable iff (!arst_n) !(arvalid && arready && rd_busy));

endmodule

`default_nettype wire

// File: verilog/ram_slave.sv
`timescale 1ns/1ps
`default_nettype none

module ram_slave (
	input  logic        clock,
	input  logic        arst_n,
	input  logic [31:0] araddr,
	input  logic        arvalid,
	input  logic [2:0]  arsize,
	output logic        arready,
	output logic [63:0] rdata,
	output logic [1:0]  rresp,
	output logic        rvalid,
	input  logic        rready,
	input  logic [31:0] awaddr,
	input  logic        awvalid,
	input  logic [2:0]  awsize,
	output logic        awready,
	input  logic [63:0] wdata,
	input  logic [7:0]  wstrb,
	input  logic        wvalid,
	output logic        wready,
	output logic [1:0]  bresp,
	output logic        bvalid,
	input  logic        bready
);

	logic [31:0] mem [lsu_pkg::ram_words];
	logic [3:0]  wait_cnt;
	logic        is_read;
	logic        idle;
	logic        rd_fire;
	logic        wr_fire;
	logic        rd_err;
	logic        wr_err;
	logic [31:0] rword;
	logic [31:0] wword;
	logic [3:0]  wlane;

	assign idle    = wait_cnt == 4'd0 && !rvalid && !bvalid;
	assign arready = idle;
	// Reads win if both arrive together.
	assign awready = idle && wvalid && !arvalid;
	assign wready  = idle && awvalid && !arvalid;
	assign rd_fire = arvalid && arready;
	assign wr_fire = awvalid && awready;

	// Wider than a word is not supported.
	assign rd_err = arsize > 3'd2;
	assign wr_err = awsize > 3'd2;

	assign wword = awaddr[2] ? wdata[63:32] : wdata[31:0];
	assign wlane = awaddr[2] ? wstrb[7:4] : wstrb[3:0];
	assign rdata = {32'h0, rword};

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			wait_cnt <= 4'd0;
			is_read  <= 1'b0;
			rvalid   <= 1'b0;
			bvalid   <= 1'b0;
		end else begin
			if (rd_fire || wr_fire) begin
				wait_cnt <= 4'(lsu_pkg::ram_wait - 1);
				is_read  <= rd_fire;
			end else if (wait_cnt != 4'd0) begin
				wait_cnt <= wait_cnt - 4'd1;
			end
			rvalid <= (wait_cnt == 4'd1 && is_read) || (rvalid && !rready);
			bvalid <= (wait_cnt == 4'd1 && !is_read) || (bvalid && !bready);
		end
	end

	// Upper address bits are ignored, so the window wraps.
	always_ff @(posedge clock) begin
		if (rd_fire) begin
			rword <= rd_err ? 32'h0 : mem[araddr[11:2]];
			rresp <= rd_err ? lsu_pkg::resp_slverr : lsu_pkg::resp_okay;
		end
		if (wr_fire) begin
			bresp <= wr_err ? lsu_pkg::resp_slverr : lsu_pkg::resp_okay;
			for (int i = 0; i < 4; i++) begin
				if (wlane[i] && !wr_err) begin
					mem[awaddr[11:2]][8*i +: 8] <= wword[8*i +: 8];
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/scratch_slave.sv
`timescale 1ns/1ps
`default_nettype none

module scratch_slave (
	input  logic        clock,
	input  logic        arst_n,
	input  logic [31:0] araddr,
	input  logic        arvalid,
	input  logic [2:0]  arsize,
	output logic        arready,
	output logic [63:0] rdata,
	output logic [1:0]  rresp,
	output logic        rvalid,
	input  logic        rready,
	input  logic [31:0] awaddr,
	input  logic        awvalid,
	input  logic [2:0]  awsize,
	output logic        awready,
	input  logic [63:0] wdata,
	input  logic [7:0]  wstrb,
	input  logic        wvalid,
	output logic        wready,
	output logic [1:0]  bresp,
	output logic        bvalid,
	input  logic        bready
);

	logic [63:0] mem [lsu_pkg::scratch_words];
	logic        rd_fire;
	logic        wr_fire;

	assign arready = !rvalid;
	// Address and data are taken together.
	assign awready = !bvalid && wvalid;
	assign wready  = !bvalid && awvalid;
	assign rd_fire = arvalid && arready;
	assign wr_fire = awvalid && awready;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			rvalid <= 1'b0;
			bvalid <= 1'b0;
		end else begin
			rvalid <= rd_fire || (rvalid && !rready);
			bvalid <= wr_fire || (bvalid && !bready);
		end
	end

	always_ff @(posedge clock) begin
		if (rd_fire) begin
			rdata <= mem[araddr[12:3]];
			rresp <= (arsize > 3'd3) ? lsu_pkg::resp_slverr : lsu_pkg::resp_okay;
		end
		if (wr_fire) begin
			bresp <= (awsize > 3'd3) ? lsu_pkg::resp_slverr : lsu_pkg::resp_okay;
			for (int i = 0; i < 8; i++) begin
				if (wstrb[i] && awsize <= 3'd3) begin
					mem[awaddr[12:3]][8*i +: 8] <= wdata[8*i +: 8];
				end
			end
		end
	end

	assert property (@(posedge clock) disable iff (!arst_n) rvalid && !rready |=> rvalid);

endmodule

`default_nettype wire
